//--- hw/McbPkg.sv
//--------------------------------------------------------------------------
// MCB shared definitions
// bus widths, USI address fields, CSR offsets and the bus structs
//--------------------------------------------------------------------------
package McbPkg;

	//----------------------------------------------------------------------
	// bus widths
	//----------------------------------------------------------------------
	// USI register bus, data and address words
	localparam int UsiWidth = 32;
	// UFI data words
	localparam int UfiWidth = 32;

	//----------------------------------------------------------------------
	// USI address fields
	//----------------------------------------------------------------------
	// block number in the top byte
	localparam int BlockAdrsMsb = 31;
	localparam int BlockAdrsLsb = 24;
	localparam int BlockWidth   = BlockAdrsMsb - BlockAdrsLsb + 1;
	// register offset in the bottom byte
	localparam int CsrOfsMsb    = 7;

	//----------------------------------------------------------------------
	// CSR offsets inside the MCB block
	//----------------------------------------------------------------------
	typedef enum logic [CsrOfsMsb:0]
	{
		// ro, version high half and custom code low half
		CsrVersion = 8'h00,
		// rw, word to push into the cache
		CsrRamWd   = 8'h04,
		// rw, bit 0 push enable
		CsrRamCtl  = 8'h08,
		// ro, bit 0 full and bit 1 empty
		CsrRamStat = 8'h0C,
		// ro, last captured UFI word
		CsrUfiRd   = 8'h10
	} McbCsrReg;

	//----------------------------------------------------------------------
	// bus structs
	//----------------------------------------------------------------------
	// processor GPIO side, two 16 bit ports
	// only bit 0 of each enable carries meaning
	typedef struct packed
	{
		logic [15:0] writeMsb;
		logic [15:0] writeLsb;
		logic [15:0] dataEn;
		logic [15:0] adrsEn;
	} McbGpioOut;

	// USI write, master out or slave in
	// adrs of zero is an idle cycle
	typedef struct packed
	{
		logic [UsiWidth-1:0] wd;
		logic [UsiWidth-1:0] adrs;
	} McbUsiWrite;

endpackage

//--- hw/McbBusBridge.sv
//--------------------------------------------------------------------------
// MCB bus bridge
// processor GPIO writes become USI master writes, USI read data
// goes back to the processor on the GPIO read port
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module McbBusBridge
(
	input  logic                        iSCLK,
	input  logic                        iSRST,
	// processor side
	input  McbPkg::McbGpioOut           gpioOut,
	output logic [McbPkg::UsiWidth-1:0] gpioRead,
	// USI master side
	input  logic [McbPkg::UsiWidth-1:0] usiRd,
	output McbPkg::McbUsiWrite          usiWr
);

//--------------------------------------------------------------------------
// master write
//--------------------------------------------------------------------------
logic [McbPkg::UsiWidth-1:0] gpioWord;

// both GPIO ports form one bus word
assign gpioWord = {gpioOut.writeMsb, gpioOut.writeLsb};

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		usiWr <= '0;
	end
	else
	begin
		// data is held until the next data enable
		if (gpioOut.dataEn[0])
		begin
			usiWr.wd <= gpioWord;
		end
		// address lives one cycle, zero means idle
		if (gpioOut.adrsEn[0])
		begin
			usiWr.adrs <= gpioWord;
		end
		else
		begin
			usiWr.adrs <= '0;
		end
	end
end

// read data straight back, MSB port and LSB port
assign gpioRead = {usiRd[31:16], usiRd[15:0]};

// firmware loads data first and the address after it
apEnableOrder: assert property (@(posedge iSCLK) disable iff (iSRST)
	!(gpioOut.dataEn[0] && gpioOut.adrsEn[0]));

endmodule

//--- hw/McbCsr.sv
//--------------------------------------------------------------------------
// MCB CSR bank
// answers USI slave writes to this block, keeps the push registers,
// makes the cache push one-shot and captures UFI read words
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module McbCsr
#(
	// block number this bank answers to
	parameter logic [McbPkg::BlockWidth-1:0] pAdrsMap = 8'h01
)
(
	input  logic                        iSCLK,
	input  logic                        iSRST,
	// USI slave side
	input  McbPkg::McbUsiWrite          usiWr,
	output logic [McbPkg::UsiWidth-1:0] usiRd,
	// identification
	input  logic [15:0]                 systemVersion,
	input  logic [15:0]                 customCode,
	// cache push side
	output logic [McbPkg::UfiWidth-1:0] pushWd,
	output logic                        pushStb,
	input  logic                        ramFull,
	input  logic                        ramEmp,
	// UFI read capture
	input  logic [McbPkg::UfiWidth-1:0] ufiRd,
	input  logic                        ufiVd
);

//--------------------------------------------------------------------------
// address decode
//--------------------------------------------------------------------------
logic               blockHit;
McbPkg::McbCsrReg   csrOfs;
logic               ofsKnown;

// nonzero address with our block number
assign blockHit = (usiWr.adrs != '0) &&
	(usiWr.adrs[McbPkg::BlockAdrsMsb:McbPkg::BlockAdrsLsb] == pAdrsMap);

// map raw offset onto the register set
always_comb
begin
	csrOfs   = McbPkg::CsrVersion;
	ofsKnown = 1'b1;
	case (usiWr.adrs[McbPkg::CsrOfsMsb:0])
		McbPkg::CsrVersion: csrOfs = McbPkg::CsrVersion;
		McbPkg::CsrRamWd:   csrOfs = McbPkg::CsrRamWd;
		McbPkg::CsrRamCtl:  csrOfs = McbPkg::CsrRamCtl;
		McbPkg::CsrRamStat: csrOfs = McbPkg::CsrRamStat;
		McbPkg::CsrUfiRd:   csrOfs = McbPkg::CsrUfiRd;
		// hole in the map
		default:            ofsKnown = 1'b0;
	endcase
end

//--------------------------------------------------------------------------
// writable registers and read-back selection
//--------------------------------------------------------------------------
logic [McbPkg::UfiWidth-1:0] ramWd;
logic                        ramCtl;
McbPkg::McbCsrReg            rdSel;
logic                        rdSelHit;
// last UFI word seen with its strobe
logic [McbPkg::UfiWidth-1:0] ufiCap;

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		ramWd    <= '0;
		ramCtl   <= 1'b0;
		rdSel    <= McbPkg::CsrVersion;
		rdSelHit <= 1'b1;
	end
	else if (blockHit)
	begin
		// any access moves the read pointer, unknown offset reads zero
		rdSel    <= csrOfs;
		rdSelHit <= ofsKnown;
		// read-only targets fall through untouched
		if (ofsKnown && (csrOfs == McbPkg::CsrRamWd))
		begin
			ramWd <= usiWr.wd;
		end
		if (ofsKnown && (csrOfs == McbPkg::CsrRamCtl))
		begin
			ramCtl <= usiWr.wd[0];
		end
	end
end

// read mux, live status and capture word
always_comb
begin
	usiRd = '0;
	if (rdSelHit)
	begin
		case (rdSel)
			McbPkg::CsrVersion: usiRd = {systemVersion, customCode};
			McbPkg::CsrRamWd:   usiRd = ramWd;
			McbPkg::CsrRamCtl:  usiRd = {{(McbPkg::UsiWidth-1){1'b0}}, ramCtl};
			McbPkg::CsrRamStat: usiRd = {{(McbPkg::UsiWidth-2){1'b0}}, ramEmp, ramFull};
			McbPkg::CsrUfiRd:   usiRd = ufiCap;
			default:            usiRd = '0;
		endcase
	end
end

//--------------------------------------------------------------------------
// push one-shot
//--------------------------------------------------------------------------
logic ramCtlDly;

// last cycle's enable, edge detect reference
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		ramCtlDly <= 1'b0;
	end
	else
	begin
		ramCtlDly <= ramCtl;
	end
end

// rising enable only, dropped when the cache is full
assign pushStb = ramCtl & ~ramCtlDly & ~ramFull;
assign pushWd  = ramWd;

//--------------------------------------------------------------------------
// UFI read capture
//--------------------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (ufiVd)
	begin
		ufiCap <= ufiRd;
	end
end

// full flag from the cache blocks a new push
apPushNotFull: assert property (@(posedge iSCLK) disable iff (iSRST)
	$rose(pushStb) |-> !ramFull);

endmodule

//--- hw/McbCacheFifo.sv
//--------------------------------------------------------------------------
// MCB cache memory
// synchronous word FIFO, filled by CSR pushes and drained on UFI ready
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module McbCacheFifo
#(
	// word count, power of two
	parameter int pFifoDepth = 16
)
(
	input  logic                        iSCLK,
	input  logic                        iSRST,
	// write side
	input  logic [McbPkg::UfiWidth-1:0] wd,
	input  logic                        we,
	output logic                        full,
	output logic                        emp,
	// read side
	input  logic                        rdy,
	output logic [McbPkg::UfiWidth-1:0] rd,
	output logic                        rvd
);

localparam int lpAdrsWidth = $clog2(pFifoDepth);

//--------------------------------------------------------------------------
// storage and pointers
//--------------------------------------------------------------------------
logic [McbPkg::UfiWidth-1:0] mem [pFifoDepth];
// extra msb tells a wrap apart from equal addresses
logic [lpAdrsWidth:0]        wrPtr;
logic [lpAdrsWidth:0]        rdPtr;
logic                        wrEn;
logic                        rdEn;

// same address, opposite lap
assign full = (wrPtr[lpAdrsWidth] != rdPtr[lpAdrsWidth]) &&
	(wrPtr[lpAdrsWidth-1:0] == rdPtr[lpAdrsWidth-1:0]);
assign emp  = (wrPtr == rdPtr);

assign wrEn = we & ~full;
assign rdEn = rdy & ~emp;

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		wrPtr <= '0;
		rdPtr <= '0;
	end
	else
	begin
		if (wrEn)
		begin
			wrPtr <= wrPtr + 1'b1;
		end
		if (rdEn)
		begin
			rdPtr <= rdPtr + 1'b1;
		end
	end
end

// word store
always_ff @(posedge iSCLK)
begin
	if (wrEn)
	begin
		mem[wrPtr[lpAdrsWidth-1:0]] <= wd;
	end
end

//--------------------------------------------------------------------------
// read register
//--------------------------------------------------------------------------
// head word, held until the next pop
always_ff @(posedge iSCLK)
begin
	if (rdEn)
	begin
		rd <= mem[rdPtr[lpAdrsWidth-1:0]];
	end
end

// one strobe per popped word
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		rvd <= 1'b0;
	end
	else
	begin
		rvd <= rdEn;
	end
end

// the CSR bank must hold pushes off while full
apNoWriteFull: assert property (@(posedge iSCLK) disable iff (iSRST)
	we |-> !full);

// a valid word always comes from a nonempty cycle
apNoReadEmpty: assert property (@(posedge iSCLK) disable iff (iSRST)
	rvd |-> $past(!emp));

endmodule

//--- hw/McbTop.sv
//--------------------------------------------------------------------------
// MCB subsystem top
// GPIO bridge beside the CSR bank, CSR bank feeding the cache memory
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module McbTop
#(
	// block number of the CSR bank
	parameter logic [McbPkg::BlockWidth-1:0] pAdrsMap   = 8'h01,
	// cache depth, power of two
	parameter int                            pFifoDepth = 16
)
(
	input  logic                        iSCLK,
	input  logic                        iSRST,
	// processor GPIO
	input  McbPkg::McbGpioOut           gpioOut,
	output logic [McbPkg::UsiWidth-1:0] gpioRead,
	// USI master
	output McbPkg::McbUsiWrite          mUsiWr,
	input  logic [McbPkg::UsiWidth-1:0] mUsiRd,
	// USI slave
	input  McbPkg::McbUsiWrite          sUsiWr,
	output logic [McbPkg::UsiWidth-1:0] sUsiRd,
	// UFI read
	input  logic [McbPkg::UfiWidth-1:0] mUfiRd,
	input  logic                        mUfiVd,
	// UFI write
	output logic [McbPkg::UfiWidth-1:0] mUfiWd,
	output logic                        mUfiWVd,
	input  logic                        mUfiRdy,
	// identification
	input  logic [15:0]                 systemVersion,
	input  logic [15:0]                 customCode
);

//--------------------------------------------------------------------------
// CSR to cache wires
//--------------------------------------------------------------------------
logic [McbPkg::UfiWidth-1:0] pushWd;
logic                        pushStb;
logic                        ramFull;
logic                        ramEmp;

// GPIO to USI master
McbBusBridge McbBusBridge_inst
(
	.iSCLK    (iSCLK),
	.iSRST    (iSRST),
	.gpioOut  (gpioOut),
	.gpioRead (gpioRead),
	.usiRd    (mUsiRd),
	.usiWr    (mUsiWr)
);

// USI slave registers
McbCsr #(
	.pAdrsMap (pAdrsMap)
) McbCsr_inst (
	.iSCLK         (iSCLK),
	.iSRST         (iSRST),
	.usiWr         (sUsiWr),
	.usiRd         (sUsiRd),
	.systemVersion (systemVersion),
	.customCode    (customCode),
	.pushWd        (pushWd),
	.pushStb       (pushStb),
	.ramFull       (ramFull),
	.ramEmp        (ramEmp),
	.ufiRd         (mUfiRd),
	.ufiVd         (mUfiVd)
);

// cache drained onto UFI
McbCacheFifo #(
	.pFifoDepth (pFifoDepth)
) McbCacheFifo_inst (
	.iSCLK (iSCLK),
	.iSRST (iSRST),
	.wd    (pushWd),
	.we    (pushStb),
	.full  (ramFull),
	.emp   (ramEmp),
	.rdy   (mUfiRdy),
	.rd    (mUfiWd),
	.rvd   (mUfiWVd)
);

endmodule

//--- sim/McbTb.sv
//--------------------------------------------------------------------------
// MCB subsystem testbench
// plays the processor, the USI slave master and the UFI side, and runs
// directed tests on bridge, CSR bank and cache memory
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module McbTb;

localparam int         lpClkPeriod  = 100;
localparam logic [7:0] lpAdrsMap    = 8'h01;
localparam int         lpFifoDepth  = 16;
// words pushed in the back-pressure test
localparam int         lpCacheWords = 8;
// cycle budget, reset + version + bridge + order + full + capture + foreign
localparam int lpTestCycles = 12 + 8 + 8
	+ lpCacheWords * 6 + (lpCacheWords * 8 + 32)
	+ (lpFifoDepth + 2) * 6 + (lpFifoDepth * 8 + 32) + 48
	+ 8 + 20;
localparam int lpWatchdogCycles = lpTestCycles + 200;

logic               iSCLK;
logic               iSRST;
McbPkg::McbGpioOut  gpioOut;
logic [31:0]        gpioRead;
McbPkg::McbUsiWrite mUsiWr;
logic [31:0]        mUsiRd;
McbPkg::McbUsiWrite sUsiWr;
logic [31:0]        sUsiRd;
logic [31:0]        mUfiRd;
logic               mUfiVd;
logic [31:0]        mUfiWd;
logic               mUfiWVd;
logic               mUfiRdy;
logic [15:0]        systemVersion;
logic [15:0]        customCode;

int          seed = 32'h3339;
int          errCount;
int          checkCount;
// words expected on UFI, in push order
logic [31:0] expQ [$];

McbTop #(
	.pAdrsMap   (lpAdrsMap),
	.pFifoDepth (lpFifoDepth)
) McbTop_inst (
	.iSCLK         (iSCLK),
	.iSRST         (iSRST),
	.gpioOut       (gpioOut),
	.gpioRead      (gpioRead),
	.mUsiWr        (mUsiWr),
	.mUsiRd        (mUsiRd),
	.sUsiWr        (sUsiWr),
	.sUsiRd        (sUsiRd),
	.mUfiRd        (mUfiRd),
	.mUfiVd        (mUfiVd),
	.mUfiWd        (mUfiWd),
	.mUfiWVd       (mUfiWVd),
	.mUfiRdy       (mUfiRdy),
	.systemVersion (systemVersion),
	.customCode    (customCode)
);

//--------------------------------------------------------------------------
// clock and watchdog
//--------------------------------------------------------------------------
initial
begin
	iSCLK = 1'b0;
	forever #(lpClkPeriod / 2) iSCLK = ~iSCLK;
end

initial
begin
	#(lpWatchdogCycles * lpClkPeriod);
	$display("Timeout: the tests did not finish within %0d clock cycles", lpWatchdogCycles);
	$display("TB FAILED");
	$finish;
end

//--------------------------------------------------------------------------
// helpers
//--------------------------------------------------------------------------
task automatic checkValue(input string name, input logic [31:0] expVal,
	input logic [31:0] actVal);
	checkCount++;
	if (actVal !== expVal)
	begin
		errCount++;
		$display("Error at %0d ns: %s expected 0x%08h, actual 0x%08h",
			$time, name, expVal, actVal);
	end
endtask

task automatic reportFailure(input string what);
	errCount++;
	$display("Failure at %0d ns: %s", $time, what);
endtask

// one USI slave cycle, returns on the falling edge after the write edge
task automatic csrAccess(input logic [7:0] block, input logic [7:0] ofs,
	input logic [31:0] data);
	@(negedge iSCLK);
	sUsiWr.wd   = data;
	sUsiWr.adrs = {block, 16'h0000, ofs};
	@(negedge iSCLK);
	sUsiWr.adrs = '0;
endtask

// data word, then enable 1, then enable 0
task automatic pushWord(input logic [31:0] word);
	csrAccess(lpAdrsMap, McbPkg::CsrRamWd, word);
	csrAccess(lpAdrsMap, McbPkg::CsrRamCtl, 32'h1);
	csrAccess(lpAdrsMap, McbPkg::CsrRamCtl, 32'h0);
endtask

// drain with ready, optionally stalled, and compare against expQ
task automatic drainCache(input int expCount, input bit stall);
	int          got;
	int          waitCycles;
	logic [31:0] rnd;
	got        = 0;
	waitCycles = 0;
	while ((got < expCount) && (waitCycles < expCount * 8 + 20))
	begin
		@(negedge iSCLK);
		if (mUfiWVd)
		begin
			got++;
			if (expQ.size() == 0)
				reportFailure("a word came out of the cache that was never pushed");
			else
				checkValue("mUfiWd", expQ.pop_front(), mUfiWd);
		end
		rnd     = $random(seed);
		mUfiRdy = stall ? rnd[0] : 1'b1;
		waitCycles++;
	end
	// ready held high, nothing more may come out
	mUfiRdy = 1'b1;
	repeat (4)
	begin
		@(negedge iSCLK);
		if (mUfiWVd)
			got++;
	end
	mUfiRdy = 1'b0;
	checkValue("mUfiWVd count", expCount, got);
endtask

//--------------------------------------------------------------------------
// directed tests
//--------------------------------------------------------------------------
task automatic versionRead();
	logic [31:0] rnd;
	repeat (2)
	begin
		rnd           = $random(seed);
		systemVersion = rnd[31:16];
		customCode    = rnd[15:0];
		csrAccess(lpAdrsMap, McbPkg::CsrVersion, 32'h0);
		checkValue("sUsiRd", rnd, sUsiRd);
	end
endtask

task automatic bridgeWrite();
	logic [31:0] dataWord;
	logic [31:0] adrsWord;
	logic [31:0] rdWord;
	dataWord = $random(seed);
	// idle is all zeros, keep the pulse visible
	adrsWord = $random(seed) | 32'h1;
	@(negedge iSCLK);
	gpioOut.writeMsb = dataWord[31:16];
	gpioOut.writeLsb = dataWord[15:0];
	gpioOut.dataEn   = 16'h0001;
	@(negedge iSCLK);
	gpioOut.dataEn   = 16'h0000;
	gpioOut.writeMsb = adrsWord[31:16];
	gpioOut.writeLsb = adrsWord[15:0];
	gpioOut.adrsEn   = 16'h0001;
	checkValue("mUsiWr.wd", dataWord, mUsiWr.wd);
	checkValue("mUsiWr.adrs", 32'h0, mUsiWr.adrs);
	@(negedge iSCLK);
	gpioOut.adrsEn = 16'h0000;
	checkValue("mUsiWr.adrs", adrsWord, mUsiWr.adrs);
	checkValue("mUsiWr.wd", dataWord, mUsiWr.wd);
	// address gone after one cycle, data held
	@(negedge iSCLK);
	checkValue("mUsiWr.adrs", 32'h0, mUsiWr.adrs);
	checkValue("mUsiWr.wd", dataWord, mUsiWr.wd);
	rdWord = $random(seed);
	mUsiRd = rdWord;
	@(negedge iSCLK);
	checkValue("gpioRead", rdWord, gpioRead);
endtask

task automatic cacheOrder();
	logic [31:0] word;
	int          i;
	mUfiRdy = 1'b0;
	for (i = 0; i < lpCacheWords; i++)
	begin
		word = $random(seed);
		expQ.push_back(word);
		pushWord(word);
	end
	// partly filled, neither flag
	csrAccess(lpAdrsMap, McbPkg::CsrRamStat, 32'h0);
	checkValue("sUsiRd", 32'h0, sUsiRd);
	drainCache(lpCacheWords, 1'b1);
	csrAccess(lpAdrsMap, McbPkg::CsrRamStat, 32'h0);
	checkValue("sUsiRd", 32'h2, sUsiRd);
endtask

task automatic cacheFullOneShot();
	logic [31:0] word;
	int          i;
	mUfiRdy = 1'b0;
	// last two pushes find the cache full and are dropped
	for (i = 0; i < lpFifoDepth + 2; i++)
	begin
		word = $random(seed);
		if (i < lpFifoDepth)
			expQ.push_back(word);
		pushWord(word);
	end
	csrAccess(lpAdrsMap, McbPkg::CsrRamStat, 32'h0);
	checkValue("sUsiRd", 32'h1, sUsiRd);
	drainCache(lpFifoDepth, 1'b0);
	csrAccess(lpAdrsMap, McbPkg::CsrRamStat, 32'h0);
	checkValue("sUsiRd", 32'h2, sUsiRd);
	// enable written 1 twice, one push only
	word = $random(seed);
	expQ.push_back(word);
	csrAccess(lpAdrsMap, McbPkg::CsrRamWd, word);
	csrAccess(lpAdrsMap, McbPkg::CsrRamCtl, 32'h1);
	csrAccess(lpAdrsMap, McbPkg::CsrRamCtl, 32'h1);
	csrAccess(lpAdrsMap, McbPkg::CsrRamCtl, 32'h0);
	drainCache(1, 1'b0);
endtask

task automatic ufiCapture();
	logic [31:0] word;
	word = $random(seed);
	@(negedge iSCLK);
	mUfiRd = word;
	mUfiVd = 1'b1;
	@(negedge iSCLK);
	// bus moves on, latched word has to stay
	mUfiVd = 1'b0;
	mUfiRd = ~word;
	csrAccess(lpAdrsMap, McbPkg::CsrUfiRd, 32'h0);
	checkValue("sUsiRd", word, sUsiRd);
endtask

task automatic foreignBlock();
	logic [31:0] word;
	logic [7:0]  otherBlock;
	otherBlock = lpAdrsMap ^ 8'h80;
	word       = $random(seed) | 32'h0000_0100;
	csrAccess(lpAdrsMap, McbPkg::CsrRamStat, 32'h0);
	checkValue("sUsiRd", 32'h2, sUsiRd);
	csrAccess(otherBlock, McbPkg::CsrRamWd, word);
	csrAccess(otherBlock, McbPkg::CsrRamCtl, 32'h1);
	csrAccess(otherBlock, McbPkg::CsrRamCtl, 32'h0);
	// still status, still empty
	checkValue("sUsiRd", 32'h2, sUsiRd);
	drainCache(0, 1'b0);
endtask

//--------------------------------------------------------------------------
// main sequence
//--------------------------------------------------------------------------
initial
begin
	errCount      = 0;
	checkCount    = 0;
	iSRST         = 1'b1;
	gpioOut       = '0;
	mUsiRd        = '0;
	sUsiWr        = '0;
	mUfiRd        = '0;
	mUfiVd        = 1'b0;
	mUfiRdy       = 1'b0;
	systemVersion = 16'h0102;
	customCode    = 16'h5A3C;
	repeat (10) @(negedge iSCLK);
	iSRST = 1'b0;
	@(negedge iSCLK);
	// reset state
	checkValue("mUsiWr.wd", 32'h0, mUsiWr.wd);
	checkValue("mUsiWr.adrs", 32'h0, mUsiWr.adrs);
	checkValue("mUfiWVd", 32'h0, {31'h0, mUfiWVd});
	checkValue("sUsiRd", {systemVersion, customCode}, sUsiRd);
	versionRead();
	bridgeWrite();
	cacheOrder();
	cacheFullOneShot();
	ufiCapture();
	foreignBlock();
	$display("checks run %0d, errors %0d", checkCount, errCount);
	if (errCount == 0)
		$display("TB PASSED");
	else
		$display("TB FAILED");
	$finish;
end

endmodule

//--- sim.f
hw/McbPkg.sv
hw/McbBusBridge.sv
hw/McbCsr.sv
hw/McbCacheFifo.sv
hw/McbTop.sv
sim/McbTb.sv

//--- Bender.yml
package:
  name: mcb_subsystem

sources:
  # RTL, package first
  - files:
      - hw/McbPkg.sv
      - hw/McbBusBridge.sv
      - hw/McbCsr.sv
      - hw/McbCacheFifo.sv
      - hw/McbTop.sv

  # testbench
  - target: simulation
    files:
      - sim/McbTb.sv
